//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_isa_pkg.sv
      - logic/pipe_bus_pkg.sv
      - logic/hazard_if.sv
      - logic/pipe_stage_reg.sv
      - logic/fetch_unit.sv
      - logic/decode_unit.sv
      - logic/execute_unit.sv
      - logic/hazard_ctrl.sv
      - logic/cpu_core.sv
  - target: simulation
    include_dirs:
      - logic
      - verif
    files:
      - verif/cpu_tb.sv

//--- logic/cpu_core.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_core
  import rv_isa_pkg::*;
  import pipe_bus_pkg::*;
(
  input  logic             ACLK,
  input  logic             ARESETn,
  input  logic             global_stall_i,
  input  logic [`XLEN-1:0] imem_rdata_i,
  input  logic [`XLEN-1:0] dmem_rdata_i,
  output logic [`XLEN-1:0] imem_addr_o,
  output logic [`XLEN-1:0] dmem_addr_o,
  output logic [`XLEN-1:0] dmem_wdata_o,
  output logic             dmem_wen_o,
  output logic             dmem_ren_o
);

  if_id_bus_t       if_id_d;
  if_id_bus_t       if_id_q;
  id_ex_bus_t       id_ex_d;
  id_ex_bus_t       id_ex_q;
  ex_mem_bus_t      ex_mem_d;
  ex_mem_bus_t      ex_mem_q;
  mem_wb_bus_t      mem_wb_d;
  mem_wb_bus_t      mem_wb_q;
  logic [`XLEN-1:0] redirect_pc;
  logic [`XLEN-1:0] mem_fwd;
  logic [`XLEN-1:0] wb_data;

  hazard_if hz (.ACLK, .ARESETn);

  fetch_unit i_fetch (
    .ACLK,
    .ARESETn,
    .global_stall_i,
    .redirect_pc_i(redirect_pc),
    .instr_i      (imem_rdata_i),
    .hz           (hz.fetch),
    .pc_o         (imem_addr_o),
    .if_id_o      (if_id_d)
  );

  pipe_stage_reg #(.payload_t(if_id_bus_t)) i_if_id (
    .ACLK, .ARESETn,
    .stall_i(global_stall_i || hz.stall_front),
    .flush_i(hz.flush_if_id),
    .d_i    (if_id_d),
    .q_o    (if_id_q)
  );

  decode_unit i_decode (
    .ACLK,
    .if_id_i  (if_id_q),
    .wb_rd_i  (mem_wb_q.rd),
    .wb_data_i(wb_data),
    .wb_wen_i (mem_wb_q.reg_wen),
    .hz       (hz.dec),
    .id_ex_o  (id_ex_d)
  );

  pipe_stage_reg #(.payload_t(id_ex_bus_t)) i_id_ex (
    .ACLK, .ARESETn,
    .stall_i(global_stall_i),
    .flush_i(hz.flush_id_ex),
    .d_i    (id_ex_d),
    .q_o    (id_ex_q)
  );

  execute_unit i_execute (
    .id_ex_i      (id_ex_q),
    .mem_fwd_i    (mem_fwd),
    .wb_fwd_i     (wb_data),
    .hz           (hz.exe),
    .ex_mem_o     (ex_mem_d),
    .redirect_pc_o(redirect_pc)
  );

  pipe_stage_reg #(.payload_t(ex_mem_bus_t)) i_ex_mem (
    .ACLK, .ARESETn,
    .stall_i(global_stall_i),
    .flush_i(1'b0),
    .d_i    (ex_mem_d),
    .q_o    (ex_mem_q)
  );

  hazard_ctrl i_hazard (.hz(hz.ctrl));

  // memory stage, the write strobe is dropped while frozen
  assign dmem_addr_o  = ex_mem_q.alu_result;
  assign dmem_wdata_o = ex_mem_q.store_data;
  assign dmem_wen_o   = ex_mem_q.mem_wen && !global_stall_i;
  assign dmem_ren_o   = ex_mem_q.mem_ren;

  // load data is not ready here, the load-use bubble covers it
  assign mem_fwd = (ex_mem_q.wb_sel == WB_PC4) ? ex_mem_q.pc4 : ex_mem_q.alu_result;

  assign mem_wb_d.alu_result = ex_mem_q.alu_result;
  assign mem_wb_d.load_data  = dmem_rdata_i;
  assign mem_wb_d.pc4        = ex_mem_q.pc4;
  assign mem_wb_d.rd         = ex_mem_q.rd;
  assign mem_wb_d.reg_wen    = ex_mem_q.reg_wen;
  assign mem_wb_d.wb_sel     = ex_mem_q.wb_sel;

  pipe_stage_reg #(.payload_t(mem_wb_bus_t)) i_mem_wb (
    .ACLK, .ARESETn,
    .stall_i(global_stall_i),
    .flush_i(1'b0),
    .d_i    (mem_wb_d),
    .q_o    (mem_wb_q)
  );

  always_comb begin
    case (mem_wb_q.wb_sel)
      WB_LOAD: wb_data = mem_wb_q.load_data;
      WB_PC4:  wb_data = mem_wb_q.pc4;
      default: wb_data = mem_wb_q.alu_result;
    endcase
  end

  // older writers seen by the controller
  assign hz.mem_rd      = ex_mem_q.rd;
  assign hz.mem_reg_wen = ex_mem_q.reg_wen;
  assign hz.wb_rd       = mem_wb_q.rd;
  assign hz.wb_reg_wen  = mem_wb_q.reg_wen;

endmodule

//--- logic/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define XLEN 32

// architectural integer registers, x0 included
`define REG_NUM 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- logic/decode_unit.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module decode_unit
  import rv_isa_pkg::*;
  import pipe_bus_pkg::*;
(
  input  logic             ACLK,
  input  if_id_bus_t       if_id_i,
  input  reg_idx_t         wb_rd_i,
  input  logic [`XLEN-1:0] wb_data_i,
  input  logic             wb_wen_i,
  hazard_if.dec            hz,
  output id_ex_bus_t       id_ex_o
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:`REG_NUM-1];

  logic [`XLEN-1:0] instr;
  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  reg_idx_t         rd_f;
  reg_idx_t         rs1_f;
  reg_idx_t         rs2_f;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;
  logic             use_rs1;
  logic             use_rs2;
  logic             op_ok;

  always_ff @(posedge ACLK) begin
    if (wb_wen_i && wb_rd_i != '0) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  assign instr  = if_id_i.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign rd_f   = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1_f  = instr[19:15];
  assign rs2_f  = instr[24:20];
  assign funct7 = instr[31:25];

  assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21],
                  1'b0};

  always_comb begin
    id_ex_o    = '0;
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    op_ok      = 1'b0;
    id_ex_o.pc = if_id_i.pc;
    case (opcode)
      OPC_OP: begin
        op_ok = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: id_ex_o.alu_op = ALU_ADD;
          10'b0100000_000: id_ex_o.alu_op = ALU_SUB;
          10'b0000000_111: id_ex_o.alu_op = ALU_AND;
          10'b0000000_110: id_ex_o.alu_op = ALU_OR;
          10'b0000000_100: id_ex_o.alu_op = ALU_XOR;
          10'b0000000_010: id_ex_o.alu_op = ALU_SLT;
          default:         op_ok = 1'b0;
        endcase
        use_rs1         = op_ok;
        use_rs2         = op_ok;
        id_ex_o.reg_wen = op_ok;
      end
      OPC_OP_IMM, OPC_LOAD: begin
        // ADDI and LW share the I-type add
        op_ok            = (opcode == OPC_OP_IMM) ? (funct3 == 3'b000) : (funct3 == 3'b010);
        use_rs1          = op_ok;
        id_ex_o.imm      = imm_i;
        id_ex_o.src2_sel = SRC2_IMM;
        id_ex_o.reg_wen  = op_ok;
        id_ex_o.mem_ren  = op_ok && (opcode == OPC_LOAD);
        id_ex_o.wb_sel   = (opcode == OPC_LOAD) ? WB_LOAD : WB_ALU;
      end
      OPC_STORE: begin
        use_rs1          = (funct3 == 3'b010);
        use_rs2          = (funct3 == 3'b010);
        id_ex_o.imm      = imm_s;
        id_ex_o.src2_sel = SRC2_IMM;
        id_ex_o.mem_wen  = (funct3 == 3'b010);
      end
      OPC_BRANCH: begin
        use_rs1        = (funct3[2:1] == 2'b00);
        use_rs2        = (funct3[2:1] == 2'b00);
        id_ex_o.imm    = imm_b;
        id_ex_o.branch = (funct3[2:1] == 2'b00);
        id_ex_o.cmp_op = funct3[0] ? CMP_NE : CMP_EQ;
      end
      OPC_JAL: begin
        op_ok           = 1'b1;
        id_ex_o.imm     = imm_j;
        id_ex_o.jump    = 1'b1;
        id_ex_o.reg_wen = 1'b1;
        id_ex_o.wb_sel  = WB_PC4;
      end
      default: begin
      end
    endcase
    id_ex_o.rd  = op_ok ? rd_f : '0;
    id_ex_o.rs1 = use_rs1 ? rs1_f : '0;
    id_ex_o.rs2 = use_rs2 ? rs2_f : '0;
    // same-cycle writeback bypasses the array
    if (id_ex_o.rs1 == '0) id_ex_o.rs1_val = '0;
    else if (wb_wen_i && wb_rd_i == id_ex_o.rs1) id_ex_o.rs1_val = wb_data_i;
    else id_ex_o.rs1_val = regs[id_ex_o.rs1];
    if (id_ex_o.rs2 == '0) id_ex_o.rs2_val = '0;
    else if (wb_wen_i && wb_rd_i == id_ex_o.rs2) id_ex_o.rs2_val = wb_data_i;
    else id_ex_o.rs2_val = regs[id_ex_o.rs2];
  end

  assign hz.id_rs1 = id_ex_o.rs1;
  assign hz.id_rs2 = id_ex_o.rs2;

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module execute_unit
  import rv_isa_pkg::*;
  import pipe_bus_pkg::*;
(
  input  id_ex_bus_t       id_ex_i,
  input  logic [`XLEN-1:0] mem_fwd_i,
  input  logic [`XLEN-1:0] wb_fwd_i,
  hazard_if.exe            hz,
  output ex_mem_bus_t      ex_mem_o,
  output logic [`XLEN-1:0] redirect_pc_o
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b_reg;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_res;
  logic             taken;

  function automatic logic [`XLEN-1:0] fwd_pick(input fwd_sel_e         sel,
                                                input logic [`XLEN-1:0] rf_val,
                                                input logic [`XLEN-1:0] mem_val,
                                                input logic [`XLEN-1:0] wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return rf_val;
    endcase
  endfunction

  assign op_a     = fwd_pick(hz.fwd_rs1, id_ex_i.rs1_val, mem_fwd_i, wb_fwd_i);
  assign op_b_reg = fwd_pick(hz.fwd_rs2, id_ex_i.rs2_val, mem_fwd_i, wb_fwd_i);
  assign op_b     = (id_ex_i.src2_sel == SRC2_IMM) ? id_ex_i.imm : op_b_reg;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_SUB: alu_res = op_a - op_b;
      ALU_AND: alu_res = op_a & op_b;
      ALU_OR:  alu_res = op_a | op_b;
      ALU_XOR: alu_res = op_a ^ op_b;
      ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_res = op_a + op_b;
    endcase
  end

  // branches compare the two register operands
  assign taken         = (op_a == op_b_reg) ^ (id_ex_i.cmp_op == CMP_NE);
  assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

  assign hz.ex_redirect = (id_ex_i.branch && taken) || id_ex_i.jump;
  assign hz.ex_rs1      = id_ex_i.rs1;
  assign hz.ex_rs2      = id_ex_i.rs2;
  assign hz.ex_rd       = id_ex_i.rd;
  assign hz.ex_is_load  = id_ex_i.mem_ren;

  assign ex_mem_o.alu_result = alu_res;
  assign ex_mem_o.store_data = op_b_reg;
  assign ex_mem_o.pc4        = id_ex_i.pc + `XLEN'd4;
  assign ex_mem_o.rd         = id_ex_i.rd;
  assign ex_mem_o.mem_ren    = id_ex_i.mem_ren;
  assign ex_mem_o.mem_wen    = id_ex_i.mem_wen;
  assign ex_mem_o.reg_wen    = id_ex_i.reg_wen;
  assign ex_mem_o.wb_sel     = id_ex_i.wb_sel;

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module fetch_unit
  import pipe_bus_pkg::*;
(
  input  logic             ACLK,
  input  logic             ARESETn,
  input  logic             global_stall_i,
  input  logic [`XLEN-1:0] redirect_pc_i,
  input  logic [`XLEN-1:0] instr_i,
  hazard_if.fetch          hz,
  output logic [`XLEN-1:0] pc_o,
  output if_id_bus_t       if_id_o
);

  logic [`XLEN-1:0] pc_q;

  // redirect from EX wins over a load-use hold
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      pc_q <= `RESET_PC;
    end else if (!global_stall_i) begin
      if (hz.ex_redirect) begin
        pc_q <= redirect_pc_i;
      end else if (!hz.stall_front) begin
        pc_q <= pc_q + `XLEN'd4;
      end
    end
  end

  assign pc_o          = pc_q;
  assign if_id_o.instr = instr_i;
  assign if_id_o.pc    = pc_q;

  a_pc_aligned: assert property (
    @(posedge ACLK) disable iff (!ARESETn)
    pc_q[1:0] == 2'b00
  );

endmodule

//--- logic/hazard_ctrl.sv
`timescale 1ns/100ps

module hazard_ctrl
  import rv_isa_pkg::*;
  import pipe_bus_pkg::*;
(
  hazard_if.ctrl hz
);

  logic load_use;

  // MEM is the younger writer, so it is checked first
  function automatic fwd_sel_e fwd_pick(input reg_idx_t src,
                                        input reg_idx_t mem_rd,
                                        input logic     mem_wen,
                                        input reg_idx_t wb_rd,
                                        input logic     wb_wen);
    if (src == '0) begin
      return FWD_RF;
    end else if (mem_wen && mem_rd == src) begin
      return FWD_MEM;
    end else if (wb_wen && wb_rd == src) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  assign hz.fwd_rs1 = fwd_pick(hz.ex_rs1, hz.mem_rd, hz.mem_reg_wen, hz.wb_rd, hz.wb_reg_wen);
  assign hz.fwd_rs2 = fwd_pick(hz.ex_rs2, hz.mem_rd, hz.mem_reg_wen, hz.wb_rd, hz.wb_reg_wen);

  // load data only exists from WB on, so the direct user waits one cycle
  assign load_use = hz.ex_is_load && (hz.ex_rd != '0) &&
                    ((hz.ex_rd == hz.id_rs1) || (hz.ex_rd == hz.id_rs2));

  // a redirect squashes the waiting user anyway
  assign hz.stall_front = load_use && !hz.ex_redirect;
  assign hz.flush_id_ex = load_use || hz.ex_redirect;
  assign hz.flush_if_id = hz.ex_redirect;

  // a load in EX never redirects
  a_no_stall_on_redirect: assert property (
    @(posedge hz.ACLK) disable iff (!hz.ARESETn)
    !(load_use && hz.ex_redirect)
  );

endmodule

//--- logic/hazard_if.sv
`timescale 1ns/100ps

interface hazard_if
  import rv_isa_pkg::*;
  import pipe_bus_pkg::*;
(
  input logic ACLK,
  input logic ARESETn
);
  // source indices in ID, zero when the instruction does not read them
  reg_idx_t id_rs1;
  reg_idx_t id_rs2;
  // instruction in EX
  reg_idx_t ex_rs1;
  reg_idx_t ex_rs2;
  reg_idx_t ex_rd;
  logic     ex_is_load;
  logic     ex_redirect;
  // older writers in MEM and WB
  reg_idx_t mem_rd;
  logic     mem_reg_wen;
  reg_idx_t wb_rd;
  logic     wb_reg_wen;
  // controller decisions
  fwd_sel_e fwd_rs1;
  fwd_sel_e fwd_rs2;
  logic     stall_front;
  logic     flush_if_id;
  logic     flush_id_ex;

  modport ctrl (
    input  ACLK, ARESETn, id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_is_load, ex_redirect,
    input  mem_rd, mem_reg_wen, wb_rd, wb_reg_wen,
    output fwd_rs1, fwd_rs2, stall_front, flush_if_id, flush_id_ex
  );
  modport dec   (output id_rs1, id_rs2);
  modport exe   (output ex_rs1, ex_rs2, ex_rd, ex_is_load, ex_redirect, input fwd_rs1, fwd_rs2);
  modport fetch (input stall_front, ex_redirect);

endinterface

//--- logic/pipe_bus_pkg.sv
`include "cpu_defs.svh"

package pipe_bus_pkg;
  import rv_isa_pkg::*;

  // where an EX operand comes from
  typedef enum logic [1:0] {
    FWD_RF,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  typedef struct packed {
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
  } if_id_bus_t;

  // all-zero is a bubble: every enable low
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] imm;
    reg_idx_t         rs1;
    reg_idx_t         rs2;
    reg_idx_t         rd;
    alu_op_e          alu_op;
    src2_sel_e        src2_sel;
    cmp_op_e          cmp_op;
    logic             branch;
    logic             jump;
    logic             mem_ren;
    logic             mem_wen;
    logic             reg_wen;
    wb_sel_e          wb_sel;
  } id_ex_bus_t;

  typedef struct packed {
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] store_data;
    logic [`XLEN-1:0] pc4;
    reg_idx_t         rd;
    logic             mem_ren;
    logic             mem_wen;
    logic             reg_wen;
    wb_sel_e          wb_sel;
  } ex_mem_bus_t;

  typedef struct packed {
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] pc4;
    reg_idx_t         rd;
    logic             reg_wen;
    wb_sel_e          wb_sel;
  } mem_wb_bus_t;

endpackage

//--- logic/pipe_stage_reg.sv
`timescale 1ns/100ps

module pipe_stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     ACLK,
  input  logic     ARESETn,
  input  logic     stall_i,
  input  logic     flush_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // stall beats flush, a held stage keeps its instruction
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      q_o <= '0;
    end else if (!stall_i) begin
      if (flush_i) begin
        q_o <= '0;
      end else begin
        q_o <= d_i;
      end
    end
  end

  // a stalled stage must present the same payload next cycle
  a_hold_on_stall: assert property (
    @(posedge ACLK) disable iff (!ARESETn)
    stall_i |=> $stable(q_o)
  );

endmodule

//--- logic/rv_isa_pkg.sv
`include "cpu_defs.svh"

package rv_isa_pkg;

  // register index, wide enough for every architectural register
  typedef logic [$clog2(`REG_NUM)-1:0] reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  // encoded like funct3[0] of BEQ and BNE
  typedef enum logic {
    CMP_EQ = 1'b0,
    CMP_NE = 1'b1
  } cmp_op_e;

  typedef enum logic {
    SRC2_REG,
    SRC2_IMM
  } src2_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_sel_e;

endpackage

//--- verif/iss_model.svh
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

// sign-extend an immediate field of the given width
function automatic logic [`XLEN-1:0] sext(input logic [`XLEN-1:0] val, input int bits);
  logic [`XLEN-1:0] mask;
  mask = ({`XLEN{1'b1}} << bits);
  return val[bits-1] ? (val | mask) : (val & ~mask);
endfunction

// executes the program in order and records loads, stores and redirect targets
task automatic run_model();
  logic [`XLEN-1:0] xr [0:`REG_NUM-1];
  logic [`XLEN-1:0] mem [0:63];
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] w;
  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic [`XLEN-1:0] res;
  logic [`XLEN-1:0] nxt;
  for (int i = 0; i < `REG_NUM; i++) xr[i] = '0;
  for (int i = 0; i < 64; i++) mem[i] = dmem_fill(i);
  pc = `RESET_PC;
  while (imem[pc[9:2]] != HALT_WORD) begin
    w   = imem[pc[9:2]];
    a   = xr[w[19:15]];
    b   = xr[w[24:20]];
    nxt = pc + 4;
    res = '0;
    case (w[6:0])
      7'b0110011: begin
        case ({w[31:25], w[14:12]})
          10'h100: res = a - b;
          10'h007: res = a & b;
          10'h006: res = a | b;
          10'h004: res = a ^ b;
          10'h002: res = ($signed(a) < $signed(b)) ? 1 : 0;
          default: res = a + b;
        endcase
        xr[w[11:7]] = res;
      end
      7'b0010011: xr[w[11:7]] = a + sext(w[31:20], 12);
      7'b0000011: begin
        res = a + sext(w[31:20], 12);
        xr[w[11:7]] = mem[res >> 2];
        exp_ld_addr.push_back(res);
      end
      7'b0100011: begin
        res = a + sext({w[31:25], w[11:7]}, 12);
        mem[res >> 2] = b;
        exp_st_addr.push_back(res);
        exp_st_data.push_back(b);
      end
      7'b1100011: begin
        if ((a == b) ^ w[12]) begin
          nxt = pc + sext({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
          exp_targets.push_back(nxt);
        end
      end
      default: begin
        // JAL, the only other opcode generated
        xr[w[11:7]] = pc + 4;
        nxt = pc + sext({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
        exp_targets.push_back(nxt);
      end
    endcase
    xr[0] = '0;
    pc = nxt;
  end
endtask

task automatic compare_store(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
  logic [`XLEN-1:0] ea;
  logic [`XLEN-1:0] ed;
  if (exp_st_addr.size() == 0) begin
    report_failure($sformatf("store to %h that the model never makes", addr));
  end else begin
    ea = exp_st_addr.pop_front();
    ed = exp_st_data.pop_front();
    if (addr !== ea || data !== ed) begin
      $display("Fail %0t: store %h <- %h, expected %h <- %h", $time, addr, data, ea, ed);
      report_failure("");
    end
  end
endtask

task automatic compare_load(input logic [`XLEN-1:0] addr);
  logic [`XLEN-1:0] ea;
  if (exp_ld_addr.size() == 0) begin
    report_failure($sformatf("load from %h that the model never makes", addr));
  end else begin
    ea = exp_ld_addr.pop_front();
    if (addr !== ea) begin
      $display("Fail %0t: load address %h, expected %h", $time, addr, ea);
      report_failure("");
    end
  end
endtask

task automatic compare_fetch(input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] got);
  if (got !== exp) begin
    $display("Fail %0t: fetch address %h, expected %h", $time, got, exp);
    report_failure("");
  end
endtask

`endif

//--- verif/cpu_tb.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_tb;

  localparam int unsigned HALT_IDX  = 200;
  localparam logic [31:0] HALT_WORD = 32'h0000_006f;
  localparam int unsigned LIMIT     = 20 * 256 + 3;

  logic             ACLK;
  logic             ARESETn;
  logic             global_stall_i;
  logic [`XLEN-1:0] imem_rdata_i;
  logic [`XLEN-1:0] dmem_rdata_i;
  logic [`XLEN-1:0] imem_addr_o;
  logic [`XLEN-1:0] dmem_addr_o;
  logic [`XLEN-1:0] dmem_wdata_o;
  logic             dmem_wen_o;
  logic             dmem_ren_o;

  logic [31:0]      imem [0:255];
  logic [`XLEN-1:0] dmem [0:63];
  logic [`XLEN-1:0] exp_st_addr [$];
  logic [`XLEN-1:0] exp_st_data [$];
  logic [`XLEN-1:0] exp_ld_addr [$];
  logic [`XLEN-1:0] exp_targets [$];
  logic             redirect_pending;
  logic             halt_seen;
  logic             stall_next;
  int unsigned      cycles;

  cpu_core i_dut (.*);

  always #20 ACLK = ~ACLK;

  assign imem_rdata_i = imem[imem_addr_o[9:2]];
  assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

  always @(posedge ACLK) begin
    if (dmem_wen_o) dmem[dmem_addr_o[7:2]] <= dmem_wdata_o;
  end

  task automatic report_failure(input string msg);
    if (msg != "") $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // depends on every address bit of the window
  function automatic logic [`XLEN-1:0] dmem_fill(input int idx);
    return 32'h5a00_0000 ^ (idx * 32'h0103_0507) ^ {26'd0, idx[5:0]};
  endfunction

  `include "iss_model.svh"

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] o, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] o, input logic [4:0] rd);
    return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
  endfunction

  // x7 only ever holds a window address, so a skipped base ADDI is harmless
  task automatic build_program();
    logic [9:0]  f;
    int unsigned i;
    int unsigned k;
    int unsigned kind;
    for (int n = 0; n < 256; n++) imem[n] = '0;
    for (i = 0; i < 7; i++) imem[i] = enc_i(12'($urandom), 5'd0, 3'd0, 5'(i + 1), 7'b0010011);
    imem[6] = enc_i(12'(4 * ($urandom % 64)), 5'd0, 3'd0, 5'd7, 7'b0010011);
    i = 7;
    while (i < HALT_IDX) begin
      kind = $urandom % 12;
      if (kind >= 5 && kind <= 7 && i + 1 >= HALT_IDX) kind = 4;
      k = 1 + $urandom % 8;
      if (i + k > HALT_IDX) k = HALT_IDX - i;
      case (kind)
        0, 1, 2, 3: begin
          case ($urandom % 6)
            0: f = 10'h000;
            1: f = 10'h100;
            2: f = 10'h007;
            3: f = 10'h006;
            4: f = 10'h004;
            default: f = 10'h002;
          endcase
          imem[i] = {f[9:3], 5'($urandom % 8), 5'($urandom % 8), f[2:0],
                     5'($urandom % 7), 7'b0110011};
        end
        4: imem[i] = enc_i(12'($urandom), 5'($urandom % 8), 3'd0, 5'($urandom % 7),
                           7'b0010011);
        5, 6, 7: begin
          imem[i] = enc_i(12'(4 * ($urandom % 64)), 5'd0, 3'd0, 5'd7, 7'b0010011);
          i++;
          if (kind == 5) imem[i] = enc_i(12'd0, 5'd7, 3'b010, 5'($urandom % 7), 7'b0000011);
          else imem[i] = {7'd0, 5'($urandom % 8), 5'd7, 3'b010, 5'd0, 7'b0100011};
        end
        8, 9, 10: imem[i] = enc_b(13'(4 * k), 5'($urandom % 8), 5'($urandom % 8),
                                  {2'b00, 1'($urandom % 2)});
        default: imem[i] = enc_j(21'(4 * k), 5'($urandom % 7));
      endcase
      i++;
    end
    imem[HALT_IDX] = HALT_WORD;
  endtask

  // the run is bounded by the program length
  always @(posedge ACLK) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      report_failure("timeout: the halt was not reached with all stores seen");
    end
  end

  always @(negedge ACLK) begin
    if (ARESETn) begin
      stall_next = ($urandom % 8 == 0);
      if (redirect_pending) begin
        if (exp_targets.size() > 0) compare_fetch(exp_targets.pop_front(), imem_addr_o);
        else compare_fetch(HALT_IDX * 4, imem_addr_o);
      end
      // the redirect lands on the next edge only if that edge is not frozen
      redirect_pending = i_dut.hz.ex_redirect && !stall_next;
      if (dmem_wen_o) compare_store(dmem_addr_o, dmem_wdata_o);
      // global_stall_i still shows the last edge, so each load is seen once
      if (dmem_ren_o && !global_stall_i) compare_load(dmem_addr_o);
      if (imem_addr_o == HALT_IDX * 4 && exp_st_addr.size() == 0 &&
          exp_ld_addr.size() == 0 && exp_targets.size() == 0)
        halt_seen = 1'b1;
      global_stall_i <= stall_next;
    end
  end

  initial begin
    ACLK             = 1'b0;
    ARESETn          = 1'b0;
    global_stall_i   = 1'b0;
    redirect_pending = 1'b0;
    halt_seen        = 1'b0;
    cycles           = 0;
    void'($urandom(45203));
    build_program();
    for (int n = 0; n < 64; n++) dmem[n] = dmem_fill(n);
    run_model();
    repeat (3) begin
      @(negedge ACLK);
      compare_fetch(`RESET_PC, imem_addr_o);
      if (dmem_wen_o !== 1'b0 || dmem_ren_o !== 1'b0)
        report_failure("memory strobes active during reset");
    end
    ARESETn <= 1'b1;
    wait (halt_seen);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+logic
+incdir+verif
logic/rv_isa_pkg.sv
logic/pipe_bus_pkg.sv
logic/hazard_if.sv
logic/pipe_stage_reg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/hazard_ctrl.sv
logic/cpu_core.sv
verif/cpu_tb.sv
